//--- sources.f
rtl/audio_clk_pkg.sv
rtl/audio_fmt_pkg.sv
rtl/sample_clk_gen.sv
rtl/channel_mixer.sv
rtl/i2s_tx.sv
rtl/audio_out_top.sv
sim/i2s_tx_chk.sv
sim/audio_out_tb.sv

//--- Makefile
# Verilator build and run for the audio output stage.
# Any variable below can be overridden on the command line.

SHELL       := /bin/bash
VERILATOR   ?= verilator
TOP         ?= audio_out_tb
FILELIST    ?= sources.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/audio_out_tb.sv
//##################
// Testbench for the audio output stage.
// Drives voices and pans, decodes the I2S frames from the pins and
// compares each word with a reference mix. Results go to the console.
//##################
`timescale 1ns/100ps

module audio_out_tb import audio_clk_pkg::*, audio_fmt_pkg::*; ();

    localparam int NUM_TESTS = 39;
    localparam int TIMEOUT_CYCLES = (NUM_TESTS * 4 + 4) * SAMPLE_DIV * 2;
    // A test lasts four frames. The third decoded frame after a change
    // always carries the new inputs.
    localparam int FRAMES_PER_TEST = 4;
    localparam int HALF_BITS = BITS_PER_FRAME / 2;

    logic                          clk;
    logic                          rst;
    logic signed [VOICE_WIDTH-1:0] voice_a;
    logic signed [VOICE_WIDTH-1:0] voice_b;
    pan_mode_t                     pan_a;
    pan_mode_t                     pan_b;
    logic                          i2s_sclk;
    logic                          i2s_ws;
    logic                          i2s_sd;

    // Decoded frames in arrival order.
    logic [DAC_WIDTH-1:0] left_q[$];
    logic [DAC_WIDTH-1:0] right_q[$];
    logic                 fmt_q[$];

    // Decoder state.
    logic                 ws_prev = 1'b0;
    logic                 synced = 1'b0;
    logic                 left_valid = 1'b0;
    logic                 pad_ok = 1'b1;
    logic                 left_ok = 1'b0;
    logic [DAC_WIDTH-1:0] shift_word = '0;
    logic [DAC_WIDTH-1:0] left_word = '0;
    int                   bit_idx = 0;

    // Handover between stimulus and compare.
    event                 start_check;
    event                 check_done;
    string                test_name;
    logic [DAC_WIDTH-1:0] exp_left;
    logic [DAC_WIDTH-1:0] exp_right;
    int                   first_idx;
    int                   err_count = 0;
    int                   pass_tests = 0;
    int                   fail_tests = 0;
    int                   cycle_cnt = 0;
    int                   chk_errs;

    audio_out_top dut (
        .clk      (clk),
        .rst      (rst),
        .voice_a  (voice_a),
        .voice_b  (voice_b),
        .pan_a    (pan_a),
        .pan_b    (pan_b),
        .i2s_sclk (i2s_sclk),
        .i2s_ws   (i2s_ws),
        .i2s_sd   (i2s_sd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // True when a voice with this pan mode feeds the given bus.
    function automatic logic feeds(input pan_mode_t p, input logic right);
        return (p == PAN_CENTER) || (right ? (p == PAN_RIGHT) : (p == PAN_LEFT));
    endfunction

    // Computes the expected converter word for one bus with plain integer arithmetic.
    function automatic logic [DAC_WIDTH-1:0] mix_ref(
        input logic signed [VOICE_WIDTH-1:0] va,
        input logic signed [VOICE_WIDTH-1:0] vb,
        input pan_mode_t pa,
        input pan_mode_t pb,
        input logic right
    );
        int sum;
        sum = 0;
        if (feeds(pa, right)) sum += int'(va);
        if (feeds(pb, right)) sum += int'(vb);
        return DAC_WIDTH'(sum * (2 ** MIX_SHIFT));
    endfunction

    // Frame decoder. The sample taken on a WS change is the last pad
    // bit of the half that just ended; the data follows it.
    always @(posedge i2s_sclk) begin
        if (i2s_ws != ws_prev) begin
            pad_ok = pad_ok && !i2s_sd && (bit_idx == HALF_BITS - 1);
            if (i2s_ws) begin
                left_word  = shift_word;
                left_ok    = pad_ok;
                left_valid = synced;
            end else begin
                if (left_valid) begin
                    left_q.push_back(left_word);
                    right_q.push_back(shift_word);
                    fmt_q.push_back(left_ok && pad_ok);
                end
                synced = 1'b1;
            end
            bit_idx    = 0;
            pad_ok     = 1'b1;
            shift_word = '0;
        end else begin
            bit_idx++;
            if (bit_idx <= DAC_WIDTH) begin
                shift_word = {shift_word[DAC_WIDTH-2:0], i2s_sd};
            end else if (i2s_sd) begin
                pad_ok = 1'b0;
            end
        end
        ws_prev = i2s_ws;
    end

    // Compare process. Checks two decoded frames per test.
    initial begin
        int errs_before;
        int need;
        forever begin
            @(start_check);
            errs_before = err_count;
            need = first_idx + 2;
            while (left_q.size() < need) @(negedge clk);
            for (int i = first_idx; i < need; i++) begin
                assert (left_q[i] == exp_left) else begin
                    $display("error: %0d ns: %s frame %0d left got %h expected %h",
                             $time, test_name, i, left_q[i], exp_left);
                    err_count++;
                end
                assert (right_q[i] == exp_right) else begin
                    $display("error: %0d ns: %s frame %0d right got %h expected %h",
                             $time, test_name, i, right_q[i], exp_right);
                    err_count++;
                end
                assert (fmt_q[i]) else begin
                    $display("error: %0d ns: %s frame %0d bad padding or WS timing",
                             $time, test_name, i);
                    err_count++;
                end
            end
            if (err_count == errs_before) begin
                pass_tests++;
                $display("test %-24s ok", test_name);
            end else begin
                fail_tests++;
                $display("test %-24s FAIL", test_name);
            end
            -> check_done;
        end
    end

    // Applies one input set and waits until the compare process is done.
    task automatic run_test(input string name, input logic signed [VOICE_WIDTH-1:0] va,
                            input logic signed [VOICE_WIDTH-1:0] vb,
                            input pan_mode_t pa, input pan_mode_t pb, input int first);
        @(negedge clk);
        voice_a = va;
        voice_b = vb;
        pan_a   = pa;
        pan_b   = pb;
        left_q.delete();
        right_q.delete();
        fmt_q.delete();
        test_name = name;
        exp_left  = mix_ref(va, vb, pa, pb, 1'b0);
        exp_right = mix_ref(va, vb, pa, pb, 1'b1);
        first_idx = first;
        -> start_check;
        @(check_done);
    endtask

    // Ends the run if the tests take far longer than they should.
    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run did not finish: no result after %0d clock cycles.", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        pan_mode_t pa;
        pan_mode_t pb;
        void'($urandom(32'h2e75));
        rst     = 1'b1;
        voice_a = '0;
        voice_b = '0;
        pan_a   = PAN_MUTE;
        pan_b   = PAN_MUTE;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!i2s_sclk && !i2s_ws && !i2s_sd) else begin
            $display("error: %0d ns: I2S pins not low after reset", $time);
            err_count++;
        end

        // The first frames come from the cleared buffers.
        run_test("reset", '0, '0, PAN_MUTE, PAN_MUTE, 0);

        for (int i = 0; i < 16; i++) begin
            pa = pan_mode_t'(2'(i / 4));
            pb = pan_mode_t'(2'(i % 4));
            run_test($sformatf("pan %s/%s", pa.name(), pb.name()),
                     16'sh1234, -16'sd5000, pa, pb, FRAMES_PER_TEST - 2);
        end

        run_test("most negative", 16'sh8000, 16'sh8000, PAN_CENTER, PAN_CENTER,
                 FRAMES_PER_TEST - 2);
        run_test("most positive", 16'sh7fff, 16'sh7fff, PAN_CENTER, PAN_CENTER,
                 FRAMES_PER_TEST - 2);

        for (int i = 0; i < 20; i++) begin
            run_test($sformatf("random %0d", i), 16'($urandom), 16'($urandom),
                     pan_mode_t'(2'($urandom)), pan_mode_t'(2'($urandom)),
                     FRAMES_PER_TEST - 2);
        end

        chk_errs = dut.u_i2s_tx.u_i2s_tx_chk.sclk_errs + dut.u_i2s_tx.u_i2s_tx_chk.pin_errs +
                   dut.u_i2s_tx.u_i2s_tx_chk.ws_errs;
        $display("Tests ok: %0d, tests with errors: %0d, pin timing errors: %0d",
                 pass_tests, fail_tests, chk_errs);
        if (fail_tests == 0 && err_count == 0 && chk_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sim/i2s_tx_chk.sv
//##################
// Pin timing checker for the I2S transmitter.
// Bound into every i2s_tx instance; checks the bit clock period,
// the edge on which WS and SD move, and the WS level length.
//##################
`timescale 1ns/100ps

module i2s_tx_chk import audio_clk_pkg::*; (
    input logic clk,
    input logic rst,
    input logic i2s_sclk,
    input logic i2s_ws,
    input logic i2s_sd
);

    // Pin values one system clock earlier.
    logic       sclk_q;
    logic       ws_q;
    logic       sd_q;
    logic       sclk_seen;
    logic       ws_seen;
    logic [7:0] since_edge;
    logic [7:0] fall_cnt;
    logic       sclk_chg;
    logic       sclk_fall;
    logic       ws_chg;
    logic       sd_chg;

    // Error counts, read by the testbench at the end of the run.
    int sclk_errs = 0;
    int pin_errs = 0;
    int ws_errs = 0;

    assign sclk_chg  = (i2s_sclk != sclk_q);
    assign sclk_fall = sclk_q && !i2s_sclk;
    assign ws_chg    = (i2s_ws != ws_q);
    assign sd_chg    = (i2s_sd != sd_q);

    // The first toggle and the first WS change after reset start from
    // a partial period, so each check arms itself on that first edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_q     <= 1'b0;
            ws_q       <= 1'b0;
            sd_q       <= 1'b0;
            sclk_seen  <= 1'b0;
            ws_seen    <= 1'b0;
            since_edge <= '0;
            fall_cnt   <= '0;
        end else begin
            sclk_q <= i2s_sclk;
            ws_q   <= i2s_ws;
            sd_q   <= i2s_sd;
            if (sclk_chg) begin
                since_edge <= 8'd1;
                sclk_seen  <= 1'b1;
            end else begin
                since_edge <= since_edge + 8'd1;
            end
            // The falling edge that moves WS is the first of the new level.
            if (ws_chg) begin
                fall_cnt <= 8'd1;
                ws_seen  <= 1'b1;
            end else if (sclk_fall) begin
                fall_cnt <= fall_cnt + 8'd1;
            end
        end
    end

    a_sclk_period: assert property (@(posedge clk) disable iff (rst)
        sclk_chg && sclk_seen |-> since_edge == 8'(SCLK_DIV))
    else begin
        $error("bit clock half period is not SCLK_DIV clocks");
        sclk_errs++;
    end

    a_pins_on_fall: assert property (@(posedge clk) disable iff (rst)
        (ws_chg || sd_chg) |-> sclk_fall)
    else begin
        $error("WS or SD moved away from a falling bit clock edge");
        pin_errs++;
    end

    a_ws_length: assert property (@(posedge clk) disable iff (rst)
        ws_chg && ws_seen |-> fall_cnt == 8'(BITS_PER_FRAME / 2))
    else begin
        $error("WS level did not last half a frame");
        ws_errs++;
    end

endmodule

bind i2s_tx i2s_tx_chk u_i2s_tx_chk (
    .clk      (clk),
    .rst      (rst),
    .i2s_sclk (i2s_sclk),
    .i2s_ws   (i2s_ws),
    .i2s_sd   (i2s_sd)
);

//--- rtl/audio_out_top.sv
//##################
// Top level of the audio output stage.
// Connects the sample divider, the channel mixer and the I2S
// transmitter. Voices and pans are levels from the synthesis core.
//##################
`timescale 1ns/100ps

module audio_out_top import audio_fmt_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic signed [VOICE_WIDTH-1:0] voice_a,
    input  logic signed [VOICE_WIDTH-1:0] voice_b,
    input  pan_mode_t                     pan_a,
    input  pan_mode_t                     pan_b,
    output logic                          i2s_sclk,
    output logic                          i2s_ws,
    output logic                          i2s_sd
);

    // One pulse per output sample.
    logic sample_clk_en;

    // Mixed stereo pair and its valid strobe.
    logic signed [DAC_WIDTH-1:0] mix_left;
    logic signed [DAC_WIDTH-1:0] mix_right;
    logic                        mix_strobe;

    sample_clk_gen u_sample_clk_gen (
        .clk           (clk),
        .rst           (rst),
        .sample_clk_en (sample_clk_en)
    );

    channel_mixer u_channel_mixer (
        .clk           (clk),
        .rst           (rst),
        .sample_clk_en (sample_clk_en),
        .voice_a       (voice_a),
        .voice_b       (voice_b),
        .pan_a         (pan_a),
        .pan_b         (pan_b),
        .mix_left      (mix_left),
        .mix_right     (mix_right),
        .mix_strobe    (mix_strobe)
    );

    // The transmitter sees the words as raw bit patterns.
    i2s_tx u_i2s_tx (
        .clk        (clk),
        .rst        (rst),
        .mix_strobe (mix_strobe),
        .mix_left   (mix_left),
        .mix_right  (mix_right),
        .i2s_sclk   (i2s_sclk),
        .i2s_ws     (i2s_ws),
        .i2s_sd     (i2s_sd)
    );

endmodule

//--- rtl/i2s_tx.sv
//##################
// Double-buffered I2S transmitter.
// Takes a stereo pair on each mix strobe and sends it as standard
// 64-bit I2S frames, MSB first, with 24 data bits per channel.
// The bit clock and all pins are derived from the system clock.
//##################
`timescale 1ns/100ps

module i2s_tx import audio_clk_pkg::*; import audio_fmt_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mix_strobe,
    input  logic [DAC_WIDTH-1:0] mix_left,
    input  logic [DAC_WIDTH-1:0] mix_right,
    output logic                 i2s_sclk,
    output logic                 i2s_ws,
    output logic                 i2s_sd
);

    // Internal bit clock, one system clock ahead of the pin.
    logic [SCLK_CNT_W-1:0] half_cnt;
    logic                  half_end;
    logic                  sclk_p0;
    logic                  bit_adv;

    // Index of the bit within the frame, 0 is the left MSB.
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic                 frame_end;

    // Stage 0 takes new samples, stage 1 is the frame being sent.
    logic [DAC_WIDTH-1:0] left_stage0;
    logic [DAC_WIDTH-1:0] right_stage0;
    logic [DAC_WIDTH-1:0] left_stage1;
    logic [DAC_WIDTH-1:0] right_stage1;

    // Bit selection for the serial output.
    logic                 right_half;
    logic [BIT_CNT_W-2:0] slot;
    logic [DAC_WIDTH-1:0] word_sel;
    logic [DAC_WIDTH-1:0] word_shift;
    logic                 ws_next;

    assign half_end = (half_cnt == SCLK_CNT_W'(SCLK_DIV - 1));

    // The internal clock is about to fall, so the next bit begins.
    assign bit_adv = half_end && sclk_p0;

    assign frame_end = bit_adv && (bit_cnt == BIT_CNT_W'(BITS_PER_FRAME - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            half_cnt <= '0;
            sclk_p0  <= 1'b0;
        end else begin
            if (half_end) begin
                half_cnt <= '0;
                sclk_p0  <= ~sclk_p0;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // The bit counter wraps naturally at the frame length.
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (bit_adv) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // A strobe always lands in stage 0.
    // Stage 1 is reloaded only between frames, so a frame on the wire
    // never mixes two samples.
    always_ff @(posedge clk) begin
        if (rst) begin
            left_stage0  <= '0;
            right_stage0 <= '0;
            left_stage1  <= '0;
            right_stage1 <= '0;
        end else begin
            if (mix_strobe) begin
                left_stage0  <= mix_left;
                right_stage0 <= mix_right;
            end
            if (frame_end) begin
                left_stage1  <= left_stage0;
                right_stage1 <= right_stage0;
            end
        end
    end

    // The upper counter bit picks the channel, the rest is the slot.
    assign right_half = bit_cnt[BIT_CNT_W-1];
    assign slot       = bit_cnt[BIT_CNT_W-2:0];
    assign word_sel   = right_half ? right_stage1 : left_stage1;

    // Shifting the word left by the slot puts the wanted bit at the top.
    // Slots past the data width shift everything out and send zeros.
    assign word_shift = word_sel << slot;

    // WS goes high one bit before the right MSB and low one bit before
    // the left MSB.
    assign ws_next = (bit_cnt >= BIT_CNT_W'(BITS_PER_FRAME / 2 - 1)) &&
                     (bit_cnt != BIT_CNT_W'(BITS_PER_FRAME - 1));

    // The pins follow the internal state by one clock.
    // The bit counter moves with the internal falling edge, so WS and
    // SD change together with the falling edge of the pin clock.
    always_ff @(posedge clk) begin
        if (rst) begin
            i2s_sclk <= 1'b0;
            i2s_ws   <= 1'b0;
            i2s_sd   <= 1'b0;
        end else begin
            i2s_sclk <= sclk_p0;
            i2s_ws   <= ws_next;
            i2s_sd   <= word_shift[DAC_WIDTH-1];
        end
    end

endmodule

//--- rtl/channel_mixer.sv
//##################
// Two-voice stereo mixer.
// Routes each voice to the left bus, the right bus, both or neither
// according to its pan mode, and widens the sums to the DAC width.
// New words are registered on the sample enable, the strobe follows.
//##################
`timescale 1ns/100ps

module channel_mixer import audio_fmt_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        sample_clk_en,
    input  logic signed [VOICE_WIDTH-1:0] voice_a,
    input  logic signed [VOICE_WIDTH-1:0] voice_b,
    input  pan_mode_t                   pan_a,
    input  pan_mode_t                   pan_b,
    output logic signed [DAC_WIDTH-1:0] mix_left,
    output logic signed [DAC_WIDTH-1:0] mix_right,
    output logic                        mix_strobe
);

    // Bus enables decoded from the pan modes.
    logic left_en_a;
    logic right_en_a;
    logic left_en_b;
    logic right_en_b;

    // Sign-extended voices and the per-bus sums.
    logic signed [SUM_WIDTH-1:0] ext_a;
    logic signed [SUM_WIDTH-1:0] ext_b;
    logic signed [SUM_WIDTH-1:0] sum_left;
    logic signed [SUM_WIDTH-1:0] sum_right;

    // Maps a pan mode onto {left enable, right enable}.
    function automatic logic [1:0] pan_route(input pan_mode_t pan);
        logic [1:0] route;
        case (pan)
            PAN_LEFT:   route = 2'b10;
            PAN_RIGHT:  route = 2'b01;
            PAN_CENTER: route = 2'b11;
            default:    route = 2'b00;
        endcase
        return route;
    endfunction

    always_comb begin
        {left_en_a, right_en_a} = pan_route(pan_a);
        {left_en_b, right_en_b} = pan_route(pan_b);
    end

    // One extra sign bit is enough, since two 16-bit values cannot
    // overflow a 17-bit sum.
    assign ext_a = {voice_a[VOICE_WIDTH-1], voice_a};
    assign ext_b = {voice_b[VOICE_WIDTH-1], voice_b};

    // A voice that does not feed a bus contributes zero to it.
    assign sum_left  = (left_en_a ? ext_a : '0) + (left_en_b ? ext_b : '0);
    assign sum_right = (right_en_a ? ext_a : '0) + (right_en_b ? ext_b : '0);

    // The sums are left aligned in the DAC word, so the low MIX_SHIFT
    // bits are always zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            mix_left   <= '0;
            mix_right  <= '0;
            mix_strobe <= 1'b0;
        end else begin
            mix_strobe <= sample_clk_en;
            if (sample_clk_en) begin
                mix_left  <= {sum_left, {MIX_SHIFT{1'b0}}};
                mix_right <= {sum_right, {MIX_SHIFT{1'b0}}};
            end
        end
    end

endmodule

//--- rtl/sample_clk_gen.sv
//##################
// Sample rate divider.
// Produces a one-cycle enable every SAMPLE_DIV system clocks, which
// paces the mixer and therefore the whole output stage.
//##################
`timescale 1ns/100ps

module sample_clk_gen import audio_clk_pkg::*; (
    input  logic clk,
    input  logic rst,
    output logic sample_clk_en
);

    // Free-running position inside the current sample period.
    logic [SAMPLE_CNT_W-1:0] div_cnt;
    logic                    div_wrap;

    // The counter is at its last value of the period.
    assign div_wrap = (div_cnt == SAMPLE_CNT_W'(SAMPLE_DIV - 1));

    // The pulse is registered on the wrap, so the first one appears
    // SAMPLE_DIV cycles after reset is released.
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt       <= '0;
            sample_clk_en <= 1'b0;
        end else begin
            sample_clk_en <= div_wrap;
            if (div_wrap) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- rtl/audio_fmt_pkg.sv
//##################
// Sample format definitions for the audio output stage.
// Holds the voice and converter widths and the pan routing modes
// used by the mixer, the transmitter and the top level.
//##################
package audio_fmt_pkg;

    // Width of each signed voice sample from the synthesis core.
    localparam int VOICE_WIDTH = 16;

    // Width of each channel word sent to the converter.
    localparam int DAC_WIDTH = 24;

    // A sum of two voices needs one extra bit.
    localparam int SUM_WIDTH = VOICE_WIDTH + 1;

    // Left shift that places the 17-bit sum at the top of the DAC word.
    localparam int MIX_SHIFT = DAC_WIDTH - SUM_WIDTH;

    // Which output buses a voice feeds.
    typedef enum logic [1:0] {
        PAN_MUTE   = 2'd0,
        PAN_LEFT   = 2'd1,
        PAN_RIGHT  = 2'd2,
        PAN_CENTER = 2'd3
    } pan_mode_t;

endpackage

//--- rtl/audio_clk_pkg.sv
//##################
// Clock and frame timing constants for the audio output stage.
// Imported by the sample divider and the I2S transmitter so that the
// sample rate and the I2S frame rate always agree.
//##################
package audio_clk_pkg;

    // System clock rate in Hz.
    localparam int CLK_FREQ = 12_288_000;

    // Output sample rate in Hz.
    localparam int SAMPLE_FREQ = 48_000;

    // System clocks per output sample.
    localparam int SAMPLE_DIV = CLK_FREQ / SAMPLE_FREQ;

    // Bit clocks in one stereo I2S frame, 32 per channel.
    localparam int BITS_PER_FRAME = 64;

    // System clocks per half period of the bit clock.
    // One frame then lasts exactly one sample period.
    localparam int SCLK_DIV = CLK_FREQ / (SAMPLE_FREQ * BITS_PER_FRAME) / 2;

    // Counter widths derived from the constants above.
    localparam int SAMPLE_CNT_W = $clog2(SAMPLE_DIV);
    localparam int SCLK_CNT_W = $clog2(SCLK_DIV);
    localparam int BIT_CNT_W = $clog2(BITS_PER_FRAME);

endpackage
